// ==== project.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_select.sv
rtl/prefetch_buffer.sv
rtl/if_id_register.sv
rtl/if_stage.sv
verification/fetch_clock_gen.sv
verification/if_stage_checker.sv
verification/if_stage_tb.sv

// ==== rtl/fetch_cfg.svh ====
//////////////////////////////////////////////////
// Fetch stage configuration
// Widths, prefetch queue depth and alignment bits
// shared by the instruction fetch RTL
//////////////////////////////////////////////////

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define FETCH_ADDR_W      32  // Byte address and PC width
`define FETCH_INSTR_W     32  // Raw instruction word width
`define FETCH_MTVEC_W     24  // Upper trap vector bits held by the CSR file
`define FETCH_IRQ_ID_W    5   // Vectored interrupt number

// Queue entries, also the cap on queued plus in-flight words
`define FETCH_QUEUE_DEPTH 2

// Low address bits forced to zero on word-aligned redirects
`define FETCH_ALIGN_W     2

`endif

// ==== rtl/fetch_pc_select.sv ====
//////////////////////////////////////////////////
// Fetch PC selection
// Picks the redirect target from the controller's
// source select and flags mtvec init on boot
//////////////////////////////////////////////////

`include "fetch_cfg.svh"

module fetch_pc_select (
  input  logic                  pc_set_i,          // Redirect strobe
  input  fetch_pkg::pc_mux_t    pc_mux_i,          // Redirect source
  input  fetch_pkg::fetch_addr_t boot_addr_i,
  input  fetch_pkg::fetch_addr_t jump_target_i,
  input  fetch_pkg::fetch_addr_t branch_target_i,
  input  fetch_pkg::fetch_addr_t mepc_i,
  input  fetch_pkg::fetch_addr_t nmi_addr_i,
  input  fetch_pkg::mtvec_base_t mtvec_addr_i,
  input  fetch_pkg::irq_id_t    irq_id_i,
  output fetch_pkg::fetch_addr_t branch_addr_o,     // Next fetch address
  output logic                  csr_mtvec_init_o   // Boot redirect seen
);

  localparam int AW = `FETCH_ADDR_W;
  localparam int LW = `FETCH_ALIGN_W;

  always_comb begin
    branch_addr_o = {boot_addr_i[AW-1:LW], {LW{1'b0}}};  // Unused encoding falls back to boot

    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT:     branch_addr_o = {boot_addr_i[AW-1:LW], {LW{1'b0}}};
      fetch_pkg::PC_JUMP:     branch_addr_o = jump_target_i;
      fetch_pkg::PC_BRANCH:   branch_addr_o = branch_target_i;
      fetch_pkg::PC_MRET:     branch_addr_o = mepc_i;
      // Exceptions share the vector base
      fetch_pkg::PC_TRAP_EXC: branch_addr_o = {mtvec_addr_i, 8'h00};
      // Interrupts land on base + 4 * id
      fetch_pkg::PC_TRAP_IRQ: branch_addr_o = {mtvec_addr_i, 1'b0, irq_id_i, {LW{1'b0}}};
      fetch_pkg::PC_TRAP_NMI: branch_addr_o = {nmi_addr_i[AW-1:LW], {LW{1'b0}}};
      default: ;
    endcase
  end

  // CSR file loads its reset mtvec on the boot jump
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

// ==== rtl/fetch_pkg.sv ====
//////////////////////////////////////////////////
// Fetch stage types
// Vector typedefs and the redirect source encoding
//////////////////////////////////////////////////

`include "fetch_cfg.svh"

package fetch_pkg;

  // Byte address or PC
  typedef logic [`FETCH_ADDR_W-1:0]   fetch_addr_t;
  typedef logic [`FETCH_INSTR_W-1:0]  instr_word_t;  // Raw instruction from the bus
  typedef logic [`FETCH_MTVEC_W-1:0]  mtvec_base_t;  // Trap vector base, upper bits
  typedef logic [`FETCH_IRQ_ID_W-1:0] irq_id_t;      // Interrupt number for vectoring

  // Redirect sources selected by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,  // Return from trap to mepc
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5,  // Vectored interrupt entry
    PC_TRAP_NMI = 3'd6
  } pc_mux_t;

endpackage

// ==== rtl/if_id_register.sv ====
//////////////////////////////////////////////////
// IF/ID pipeline register
// Hands instruction and PC to decode, frozen while
// decode is stalled
//////////////////////////////////////////////////

module if_id_register (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   capture_i,         // Stage valid and decode ready
  input  logic                   id_ready_i,
  input  fetch_pkg::instr_word_t instr_i,
  input  fetch_pkg::fetch_addr_t pc_i,
  output logic                   id_instr_valid_o,
  output fetch_pkg::instr_word_t id_instr_o,
  output fetch_pkg::fetch_addr_t id_pc_o
);

  // Valid bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_instr_valid_o <= 1'b0;
    end else if (capture_i) begin
      id_instr_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      id_instr_valid_o <= 1'b0;  // Decode consumed it, nothing new
    end
  end

  // Payload only moves on a capture
  always_ff @(posedge clk) begin
    if (capture_i) begin
      id_instr_o <= instr_i;
      id_pc_o    <= pc_i;
    end
  end

endmodule

// ==== rtl/if_stage.sv ====
//////////////////////////////////////////////////
// Instruction fetch stage
// Redirect selection, prefetching over the bus and
// the IF/ID register with halt and kill control
//////////////////////////////////////////////////

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // Redirect control and targets
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_mux_t     pc_mux_i,
  input  fetch_pkg::fetch_addr_t boot_addr_i,
  input  fetch_pkg::fetch_addr_t jump_target_i,
  input  fetch_pkg::fetch_addr_t branch_target_i,
  input  fetch_pkg::fetch_addr_t mepc_i,
  input  fetch_pkg::fetch_addr_t nmi_addr_i,
  input  fetch_pkg::mtvec_base_t mtvec_addr_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  logic                   halt_if_i,
  input  logic                   kill_if_i,
  input  logic                   id_ready_i,
  // Instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::fetch_addr_t instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_word_t instr_rdata_i,
  // Stage status and IF/ID outputs
  output logic                   if_valid_o,
  output fetch_pkg::fetch_addr_t pc_if_o,
  output logic                   csr_mtvec_init_o,
  output logic                   if_busy_o,
  output logic                   id_instr_valid_o,
  output fetch_pkg::instr_word_t id_instr_o,
  output fetch_pkg::fetch_addr_t id_pc_o
);

  fetch_pkg::fetch_addr_t branch_addr;
  fetch_pkg::instr_word_t fetch_instr;
  logic                   fetch_valid;
  logic                   fetch_ready;

  fetch_pc_select u_pc_select (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .nmi_addr_i       (nmi_addr_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_buffer u_prefetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_instr_o  (fetch_instr),
    .fetch_addr_o   (pc_if_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (if_busy_o)
  );

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  // Kill drains the queue, halt freezes it
  assign fetch_ready = kill_if_i || (id_ready_i && !halt_if_i);
  assign if_valid_o  = fetch_valid && !halt_if_i && !kill_if_i;

  if_id_register u_if_id (
    .clk              (clk),
    .rst_n            (rst_n),
    .capture_i        (if_valid_o && id_ready_i),
    .id_ready_i       (id_ready_i),
    .instr_i          (fetch_instr),
    .pc_i             (pc_if_o),
    .id_instr_valid_o (id_instr_valid_o),
    .id_instr_o       (id_instr_o),
    .id_pc_o          (id_pc_o)
  );

endmodule

// ==== rtl/prefetch_buffer.sv ====
//////////////////////////////////////////////////
// Prefetch buffer
// Sequences instruction bus requests, tracks and
// drops stale responses, and queues fetched words
//////////////////////////////////////////////////

`include "fetch_cfg.svh"

module prefetch_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   branch_i,       // Redirect, flushes the queue
  input  fetch_pkg::fetch_addr_t branch_addr_i,
  input  logic                   fetch_ready_i,  // Stage takes the head word
  output logic                   fetch_valid_o,
  output fetch_pkg::instr_word_t fetch_instr_o,
  output fetch_pkg::fetch_addr_t fetch_addr_o,   // PC of the head word
  output logic                   instr_req_o,
  output fetch_pkg::fetch_addr_t instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_word_t instr_rdata_i,
  output logic                   busy_o
);

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  fetch_pkg::fetch_addr_t addr_q;        // Address on the bus or next to request
  fetch_pkg::fetch_addr_t redir_addr_q;  // Target parked behind an ungranted request
  fetch_pkg::fetch_addr_t head_pc_q;
  logic                   fetch_en_q;    // Set by the first redirect
  logic                   req_hold_q;    // Request left ungranted last cycle
  logic                   redir_pend_q;
  logic [CNT_W-1:0]       out_cnt_q;     // Responses still owed by the bus
  logic [CNT_W-1:0]       out_cnt_n;
  logic [CNT_W-1:0]       disc_cnt_q;    // Owed responses that belong to an old path
  logic [CNT_W-1:0]       q_cnt_q;
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W:0]         fill_lvl;
  logic                   room;
  logic                   req_acc;
  logic                   req_stuck;
  logic                   resp_keep;
  logic                   pop;

  fetch_pkg::instr_word_t queue_mem [DEPTH];

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Bus request side
  //////////////////////////////////////////////////

  assign fill_lvl = {1'b0, q_cnt_q} + {1'b0, out_cnt_q};
  assign room     = fill_lvl < (CNT_W + 1)'(DEPTH);  // Every word in flight has a slot

  // No fresh request in a redirect cycle, a held one must stay up
  assign instr_req_o  = req_hold_q || (fetch_en_q && room && !branch_i);
  assign instr_addr_o = addr_q;

  assign req_acc   = instr_req_o && instr_gnt_i;
  assign req_stuck = instr_req_o && !instr_gnt_i;
  assign out_cnt_n = out_cnt_q + CNT_W'(req_acc) - CNT_W'(instr_rvalid_i);

  // Old-path data is dropped, including whatever arrives with the redirect
  assign resp_keep = instr_rvalid_i && (disc_cnt_q == '0) && !branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      req_hold_q   <= 1'b0;
      redir_pend_q <= 1'b0;
      addr_q       <= '0;
      redir_addr_q <= '0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
    end else begin
      req_hold_q <= req_stuck;
      out_cnt_q  <= out_cnt_n;
      if (branch_i) begin
        fetch_en_q <= 1'b1;
        disc_cnt_q <= out_cnt_n + CNT_W'(req_stuck);  // Stuck request is stale too
        if (req_stuck) begin
          redir_pend_q <= 1'b1;            // Wait for the grant before switching
          redir_addr_q <= branch_addr_i;
        end else begin
          redir_pend_q <= 1'b0;
          addr_q       <= branch_addr_i;
        end
      end else begin
        if (instr_rvalid_i && (disc_cnt_q != '0)) begin
          disc_cnt_q <= disc_cnt_q - 1'b1;
        end
        if (req_acc) begin
          redir_pend_q <= 1'b0;
          addr_q       <= redir_pend_q ? redir_addr_q : addr_q + 32'd4;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Instruction queue
  //////////////////////////////////////////////////

  assign pop = fetch_valid_o && fetch_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_cnt_q   <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      head_pc_q <= '0;
    end else if (branch_i) begin
      q_cnt_q   <= '0;              // Flush
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      head_pc_q <= branch_addr_i;   // First kept word sits at the target
    end else begin
      q_cnt_q <= q_cnt_q + CNT_W'(resp_keep) - CNT_W'(pop);
      if (resp_keep) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) begin
        rd_ptr_q  <= ptr_inc(rd_ptr_q);
        head_pc_q <= head_pc_q + 32'd4;  // Words after a redirect are sequential
      end
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (resp_keep) queue_mem[wr_ptr_q] <= instr_rdata_i;
  end

  assign fetch_valid_o = (q_cnt_q != '0);
  assign fetch_instr_o = queue_mem[rd_ptr_q];
  assign fetch_addr_o  = head_pc_q;
  assign busy_o        = (out_cnt_q != '0);  // Bus still owes data

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module if_stage_tb -o if_stage_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/if_stage_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// ==== verification/fetch_clock_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock source
// Free running clock, 100 time unit period
//////////////////////////////////////////////////

module fetch_clock_gen (
  output logic clk_o
);

  initial clk_o = 1'b0;
  always #50 clk_o = ~clk_o;  // Half period

endmodule

// ==== verification/if_stage_checker.sv ====
//////////////////////////////////////////////////
// Fetch stage protocol checker
// Bus request stability, response accounting and
// stage valid rules, bound into the DUT
//////////////////////////////////////////////////

module if_stage_checker (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   pc_set_i,
  input logic                   halt_if_i,
  input logic                   kill_if_i,
  input logic                   instr_req_o,
  input fetch_pkg::fetch_addr_t instr_addr_o,
  input logic                   instr_gnt_i,
  input logic                   instr_rvalid_i,
  input logic                   if_valid_o,
  input logic                   if_busy_o
);

  logic redirect_seen_q;  // First redirect since reset

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) redirect_seen_q <= 1'b0;
    else if (pc_set_i) redirect_seen_q <= 1'b1;
  end

  // Ungranted request holds address and stays up
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("ungranted request dropped or changed address");

  a_rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> if_busy_o)
    else $error("response arrived with nothing outstanding");

  a_halt_kill: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_if_i || kill_if_i) |-> !if_valid_o)
    else $error("stage valid while halted or killed");

  a_boot_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !redirect_seen_q |-> !if_valid_o)
    else $error("stage valid before the first redirect");

endmodule

// ==== verification/if_stage_input.txt ====
# name src target irq stall mode count
# src 0 boot 1 jump 2 branch 3 mret 4 exc 5 irq 6 nmi; stall bit i = decode ready; mode 1 halt 2 kill
boot       0 00001002 00 ff 0 8
jump       1 00002000 00 ff 0 6
branch     2 00003104 00 b5 0 6
mret       3 00004010 00 ff 0 5
trap_exc   4 00051234 00 ff 0 4
trap_irq   5 00060000 13 ff 0 4
trap_nmi   6 00007ffe 00 ff 0 4
stall      1 00008000 00 49 0 10
halt       2 00009000 00 6d 1 10
kill       1 0000a000 00 ff 2 6
random     1 0000b000 00 f7 0 40

// ==== verification/if_stage_tb.sv ====
//////////////////////////////////////////////////
// Fetch stage testbench
// Bus memory model with random delays, scenarios
// read from the stimulus file, scoreboard report
//////////////////////////////////////////////////

module if_stage_tb;

  localparam logic [31:0] MEM_PATTERN = 32'h5a3c_96e1;  // Memory word = address xor this
  localparam int          WORD_TIMEOUT = 60;            // Cycles allowed per delivered word

  logic                   clk;
  logic                   rst_n;
  logic                   pc_set;
  fetch_pkg::pc_mux_t     pc_mux;
  fetch_pkg::fetch_addr_t boot_addr, jump_target, branch_target, mepc, nmi_addr;
  fetch_pkg::mtvec_base_t mtvec_addr;
  fetch_pkg::irq_id_t     irq_id;
  logic                   halt_if, kill_if, id_ready;
  logic                   instr_req, instr_gnt, instr_rvalid;
  fetch_pkg::fetch_addr_t instr_addr;
  fetch_pkg::instr_word_t instr_rdata;
  logic                   if_valid, csr_mtvec_init, if_busy, id_instr_valid;
  fetch_pkg::fetch_addr_t pc_if, id_pc;
  fetch_pkg::instr_word_t id_instr;

  // Scoreboard state
  int unsigned lcg_state = 32'd44981;
  int          error_count = 0;
  int          check_count = 0;
  int          scenario_count = 0;
  logic        aborted = 1'b0;    // Timeout or missing stimulus
  string       cur_name = "reset";
  logic        ready_q = 1'b0;     // id_ready during the cycle just ended
  logic        new_word;
  logic        held_valid = 1'b0;
  logic [31:0] held_instr, held_pc;

  // Memory model state
  logic [31:0] resp_addr[$];
  int unsigned resp_due[$];
  int unsigned mem_cycle = 0;
  int unsigned last_due = 0;
  int unsigned gnt_wait = 0;
  int unsigned resp_delay = 0;

  fetch_clock_gen u_clk (.clk_o(clk));

  if_stage UUT (
    .clk (clk), .rst_n (rst_n),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux),
    .boot_addr_i (boot_addr), .jump_target_i (jump_target),
    .branch_target_i (branch_target), .mepc_i (mepc), .nmi_addr_i (nmi_addr),
    .mtvec_addr_i (mtvec_addr), .irq_id_i (irq_id),
    .halt_if_i (halt_if), .kill_if_i (kill_if), .id_ready_i (id_ready),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata),
    .if_valid_o (if_valid), .pc_if_o (pc_if), .csr_mtvec_init_o (csr_mtvec_init),
    .if_busy_o (if_busy), .id_instr_valid_o (id_instr_valid),
    .id_instr_o (id_instr), .id_pc_o (id_pc)
  );

  bind if_stage if_stage_checker u_checker (.*);

  function int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  // Redirect target as the address rules define it
  function logic [31:0] expected_start(input int src, input logic [31:0] t, input logic [4:0] irq);
    case (src)
      0:       return {t[31:2], 2'b00};
      4:       return {t[31:8], 8'h00};
      5:       return {t[31:8], 1'b0, irq, 2'b00};
      6:       return {t[31:2], 2'b00};
      default: return t;  // Jump, branch, mret pass through
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("error %s %s expected %h actual %h", cur_name, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Instruction memory, random grant and data delay
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      resp_addr.delete();
      resp_due.delete();
      gnt_wait = 0;
    end else begin
      mem_cycle++;
      if (instr_rvalid) void'(resp_addr.pop_front());
      if (instr_rvalid) void'(resp_due.pop_front());
      if (instr_req && instr_gnt) begin
        resp_delay = lcg_next() % 2;  // Data 1 or 2 cycles after the grant
        last_due   = (mem_cycle + resp_delay > last_due) ? mem_cycle + resp_delay
                                                         : last_due + 1;
        resp_addr.push_back(instr_addr);
        resp_due.push_back(last_due);
        gnt_wait = lcg_next() % 3;  // Next request waits 0 to 2 cycles
      end else if (instr_req && gnt_wait > 0) begin
        gnt_wait--;
      end
    end
    #10;
    instr_gnt    = rst_n && (gnt_wait == 0);
    instr_rvalid = rst_n && (resp_due.size() > 0) && (resp_due[0] <= mem_cycle);
    instr_rdata  = instr_rvalid ? (resp_addr[0] ^ MEM_PATTERN) : '0;
  end

  //////////////////////////////////////////////////
  // Cycle stepping and scenarios
  //////////////////////////////////////////////////

  // Sample the ended cycle, then drive the next one
  task automatic next_cycle(input logic ready, input logic halt, input logic kill,
                            input logic set, input fetch_pkg::pc_mux_t mux);
    @(posedge clk);
    #5;
    new_word = ready_q && id_instr_valid;  // Register moved only if decode was ready
    if (!ready_q && held_valid) begin
      check_value("held valid", 32'd1, {31'b0, id_instr_valid});
      check_value("held instr", held_instr, id_instr);
      check_value("held pc", held_pc, id_pc);
    end
    held_valid = id_instr_valid;
    held_instr = id_instr;
    held_pc    = id_pc;
    #5;
    id_ready = ready;
    halt_if  = halt;
    kill_if  = kill;
    pc_set   = set;
    pc_mux   = mux;
    ready_q  = ready;
    #40;
    check_value("mtvec init", {31'b0, set && (mux == fetch_pkg::PC_BOOT)},
                {31'b0, csr_mtvec_init});
    // Busy while the memory still owes a response
    check_value("busy", {31'b0, (resp_addr.size() != 0)}, {31'b0, if_busy});
    if (halt || kill) check_value("if_valid under halt", 32'd0, {31'b0, if_valid});
  endtask

  task automatic run_scenario(input int src, input logic [31:0] target, input logic [4:0] irq,
                              input logic [7:0] stall, input int mode, input int count);
    fetch_pkg::pc_mux_t mux;
    logic [31:0]        pc_exp;
    int                 got;
    int                 idle;
    int                 cyc;
    int                 errs_before;
    logic               rdy;
    logic               hlt;
    mux = fetch_pkg::pc_mux_t'(src);
    errs_before = error_count;
    pc_exp = expected_start(src, target, irq);
    boot_addr     = target;
    jump_target   = target;
    branch_target = target;
    mepc          = target;
    nmi_addr      = target;
    mtvec_addr    = target[31:8];
    irq_id        = irq;
    if (mode == 2) begin
      next_cycle(1'b0, 1'b0, 1'b0, 1'b1, mux);
      repeat (6) begin
        next_cycle(1'b1, 1'b0, 1'b1, 1'b0, mux);  // Killed, words get discarded
        if (new_word) begin
          error_count++;
          $display("%s: a word popped while killed reached decode", cur_name);
        end
      end
    end
    next_cycle(1'b0, 1'b0, 1'b0, 1'b1, mux);  // Redirect with decode stalled
    got  = 0;
    idle = 0;
    cyc  = 0;
    while (got < count && !aborted) begin
      rdy = (mode == 1) ? 1'b1 : stall[cyc % 8];
      hlt = (mode == 1) ? !stall[cyc % 8] : 1'b0;
      next_cycle(rdy, hlt, 1'b0, 1'b0, mux);
      cyc++;
      if (new_word) begin
        check_value("pc", pc_exp, id_pc);
        check_value("instr", pc_exp ^ MEM_PATTERN, id_instr);
        pc_exp = pc_exp + 32'd4;
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > WORD_TIMEOUT) begin
          $display("%s: timed out waiting for instruction %0d", cur_name, got);
          aborted = 1'b1;
        end
      end
      if (if_valid) check_value("pc_if", pc_exp, pc_if);  // Queue head is the next word
    end
    scenario_count++;
    $display("%s: %0d words, %0d errors", cur_name, got, error_count - errs_before);
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       name;
    int          src;
    int          mode;
    int          count;
    logic [31:0] target;
    logic [31:0] irq;
    logic [31:0] stall;
    rst_n = 1'b0;
    pc_set = 1'b0;
    pc_mux = fetch_pkg::PC_BOOT;
    boot_addr = '0;
    jump_target = '0;
    branch_target = '0;
    mepc = '0;
    nmi_addr = '0;
    mtvec_addr = '0;
    irq_id = '0;
    halt_if = 1'b0;
    kill_if = 1'b0;
    id_ready = 1'b0;
    instr_gnt = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata = '0;
    repeat (5) @(posedge clk);
    #10 rst_n = 1'b1;
    fd = $fopen("verification/if_stage_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%s %d %h %h %h %d %d", name, src, target, irq, stall, mode, count);
        if (n == 7) begin
          cur_name = name;
          run_scenario(src, target, irq[4:0], stall[7:0], mode, count);
        end
      end
    end
    if (fd != 0) $fclose(fd);
    $display("scenarios %0d, checks %0d, errors %0d", scenario_count, check_count, error_count);
    if (aborted || error_count != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule
